// ==== list.f ====
verilog/div_data_pkg.sv
verilog/div_ctrl_pkg.sv
verilog/div_datapath.sv
verilog/div_controller.sv
verilog/restoring_divider.sv
test/div_asserts.sv
test/div_checker.sv
test/restoring_divider_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the restoring divider

VERILATOR ?= verilator
TOP       ?= restoring_divider_tb
LINT_TOP  ?= $(TOP)
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failures found
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a missing result line counts as a failure too
run: build
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/restoring_divider_tb.sv ====
// divider testbench: clock and reset, stimulus table with random rows, checker and assertion hookup
`timescale 1ns/1ps
`default_nettype none

module restoring_divider_tb
    import div_data_pkg::*;
();

    localparam int data_width   = div_default_width;
    localparam int random_rows  = 24;
    // cycles allowed for one division
    localparam int done_timeout = 4 * data_width;

    // one stimulus row
    typedef struct {
        logic [127:0]          name;
        logic [data_width-1:0] dvd;
        logic [data_width-1:0] dsr;
        bit                    again;
    } row_t;

    logic                  clk;
    logic                  reset;
    logic                  start;
    logic [data_width-1:0] dividend;
    logic [data_width-1:0] divisor;
    logic                  busy;
    logic                  done;
    logic [data_width-1:0] quotient;
    logic [data_width-1:0] remainder;
    logic [127:0]          test_name;

    int   mismatch_count;
    int   error_count;
    int   timeout_count;
    int   assert_count;
    int   seed;
    row_t rows[$];

    // 4 ns period
    always #2 clk = ~clk;

    restoring_divider #(
        .data_width (data_width)
    ) dut (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .dividend  (dividend),
        .divisor   (divisor),
        .busy      (busy),
        .done      (done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    div_checker #(
        .data_width (data_width)
    ) u_checker (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .busy           (busy),
        .done           (done),
        .dividend       (dividend),
        .divisor        (divisor),
        .quotient       (quotient),
        .remainder      (remainder),
        .test_name      (test_name),
        .mismatch_count (mismatch_count),
        .error_count    (error_count)
    );

    bind div_controller div_asserts u_asserts (
        .clk       (clk),
        .reset     (reset),
        .load      (load),
        .step      (step),
        .last_step (last_step),
        .busy      (busy),
        .done      (done),
        .state     (state)
    );

    task automatic add_row(input logic [127:0] name, input logic [data_width-1:0] dvd,
                           input logic [data_width-1:0] dsr, input bit again);
        row_t r;
        r.name  = name;
        r.dvd   = dvd;
        r.dsr   = dsr;
        r.again = again;
        rows.push_back(r);
    endtask

    task automatic fill_random_rows();
        row_t         r;
        logic [127:0] nm;
        int           raw;
        int           i;
        for (i = 0; i < random_rows; i++) begin
            $sformat(nm, "random_%0d", i);
            r.name = nm;
            raw    = $random(seed);
            r.dvd  = raw[data_width-1:0];
            raw    = $random(seed);
            r.dsr  = raw[data_width-1:0];
            // narrow divisor now and then, larger quotients
            if (i % 3 == 1) begin
                r.dsr = r.dsr >> (data_width / 2);
            end
            r.again = 1'b0;
            rows.push_back(r);
        end
    endtask

    // called half a nanosecond after a rising edge
    task automatic apply_row(input row_t r);
        int n;
        bit got_done;
        test_name = r.name;
        dividend  = r.dvd;
        divisor   = r.dsr;
        start     = 1'b1;
        @(posedge clk);
        #0.5;
        start = 1'b0;
        // second pulse mid-run with other operands
        if (r.again) begin
            @(posedge clk);
            #0.5;
            dividend = ~r.dvd;
            divisor  = ~r.dsr;
            start    = 1'b1;
            @(posedge clk);
            #0.5;
            start = 1'b0;
        end
        got_done = 1'b0;
        for (n = 0; n < done_timeout && !got_done; n++) begin
            @(negedge clk);
            got_done = done;
        end
        if (!got_done) begin
            $display("Timeout: no done for test %0s within %0d cycles", r.name, done_timeout);
            timeout_count = timeout_count + 1;
        end
        @(posedge clk);
        #0.5;
    endtask

    initial begin
        int i;
        clk       = 1'b0;
        reset     = 1'b0;
        start     = 1'b0;
        dividend  = '0;
        divisor   = '0;
        test_name = "after_reset";
        seed      = 84585;

        // directed rows first
        add_row("small_dividend", 25, 100, 1'b0);
        add_row("exact_multiple", 1200, 12, 1'b0);
        add_row("divisor_one", 48879, 1, 1'b0);
        add_row("all_ones", '1, '1, 1'b0);
        add_row("zero_dividend", 0, 77, 1'b0);
        add_row("max_by_two", '1, 2, 1'b0);
        add_row("div_by_zero", 4660, 0, 1'b0);
        add_row("zero_by_zero", 0, 0, 1'b0);
        add_row("retrigger_busy", 50000, 7, 1'b1);
        fill_random_rows();

        repeat (4) @(posedge clk);
        #0.5;
        reset = 1'b1;
        // idle stretch, reset values visible to the checker
        repeat (3) @(posedge clk);
        #0.5;

        for (i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
        end
        // trailing idle cycles catch a stray done
        repeat (4) @(posedge clk);
        #0.5;

        assert_count = dut.u_ctrl.u_asserts.done_fails + dut.u_ctrl.u_asserts.load_fails
                     + dut.u_ctrl.u_asserts.reset_fails + dut.u_ctrl.u_asserts.step_fails;
        $display("Summary: %0d timeouts, %0d mismatches, %0d other errors, %0d assertion failures",
                 timeout_count, mismatch_count, error_count, assert_count);
        if (timeout_count + mismatch_count + error_count + assert_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/div_checker.sv ====
// divider checker: latches operands at accepted start, compares results and done timing
`timescale 1ns/1ps
`default_nettype none

module div_checker #(
    parameter int data_width = 16
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  busy,
    input  logic                  done,
    input  logic [data_width-1:0] dividend,
    input  logic [data_width-1:0] divisor,
    input  logic [data_width-1:0] quotient,
    input  logic [data_width-1:0] remainder,
    input  logic [127:0]          test_name,
    output int                    mismatch_count,
    output int                    error_count
);

    // operands and name of the division in flight
    logic [data_width-1:0] lat_dvd;
    logic [data_width-1:0] lat_dsr;
    logic [127:0]          lat_name;
    logic [data_width-1:0] exp_q;
    logic [data_width-1:0] exp_r;
    // tracking flags
    logic                  pending;
    logic                  seen_start;
    logic                  after_done;
    // edges since the accepting edge
    int                    edges;

    task automatic report_mismatch(input logic [127:0] name, input string what,
                                   input logic [data_width-1:0] expected,
                                   input logic [data_width-1:0] actual);
        $display("Mismatch %0s %s: expected %0d, actual %0d", name, what, expected, actual);
        mismatch_count = mismatch_count + 1;
    endtask

    // samples are taken at the rising edge, before the DUT registers update
    always @(posedge clk) begin
        if (!reset) begin
            pending    = 1'b0;
            seen_start = 1'b0;
            after_done = 1'b0;
            edges      = 0;
        end else begin
            // cycle after the done pulse must be idle
            if (after_done) begin
                after_done = 1'b0;
                if (busy) begin
                    $display("Error: busy still high after done of %0s", lat_name);
                    error_count = error_count + 1;
                end
            end
            // nothing started yet, outputs must hold their reset values
            if (!seen_start) begin
                if (busy || done) begin
                    $display("Error: busy or done high before any start");
                    error_count = error_count + 1;
                end
                if (quotient != '0) begin
                    report_mismatch("after_reset", "quotient", '0, quotient);
                end
                if (remainder != '0) begin
                    report_mismatch("after_reset", "remainder", '0, remainder);
                end
            end
            if (pending) begin
                edges = edges + 1;
                if (!busy) begin
                    $display("Error: busy dropped during %0s", lat_name);
                    error_count = error_count + 1;
                end
                if (done) begin
                    // done sampled one edge after the edge that raised it
                    if (edges - 1 != data_width) begin
                        $display("Mismatch %0s done latency: expected %0d, actual %0d",
                                 lat_name, data_width, edges - 1);
                        mismatch_count = mismatch_count + 1;
                    end
                    // zero divisor: all ones and the dividend back
                    if (lat_dsr == '0) begin
                        exp_q = '1;
                        exp_r = lat_dvd;
                    end else begin
                        exp_q = lat_dvd / lat_dsr;
                        exp_r = lat_dvd % lat_dsr;
                    end
                    if (quotient != exp_q) begin
                        report_mismatch(lat_name, "quotient", exp_q, quotient);
                    end
                    if (remainder != exp_r) begin
                        report_mismatch(lat_name, "remainder", exp_r, remainder);
                    end
                    pending    = 1'b0;
                    after_done = 1'b1;
                end
            end else if (done) begin
                $display("Error: done pulse with no division in progress");
                error_count = error_count + 1;
            end
            // accepted start, later pulses while busy are ignored
            if (start && !busy) begin
                lat_dvd    = dividend;
                lat_dsr    = divisor;
                lat_name   = test_name;
                pending    = 1'b1;
                seen_start = 1'b1;
                edges      = 0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/div_asserts.sv ====
// divider controller assertions: done pulse width, load and last step sequencing, reset state
`timescale 1ns/1ps
`default_nettype none

module div_asserts
    import div_ctrl_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       load,
    input logic       step,
    input logic       last_step,
    input logic       busy,
    input logic       done,
    input div_state_t state
);

    // failure counts, one per property, read by the testbench
    int done_fails;
    int load_fails;
    int reset_fails;
    int step_fails;

    // done is a single-cycle pulse
    a_done_single: assert property (@(posedge clk) disable iff (!reset) done |=> !done)
        else begin
            $error("done stayed high for two cycles");
            done_fails = done_fails + 1;
        end

    // accepted start moves the sequencer into run
    a_load_run: assert property (@(posedge clk) disable iff (!reset)
        load |=> state == state_run)
        else begin
            $error("load strobe not followed by the run state");
            load_fails = load_fails + 1;
        end

    // first cycle out of reset is quiet
    a_reset_quiet: assert property (@(posedge clk) $rose(reset) |-> !busy && !done)
        else begin
            $error("busy or done high right after reset release");
            reset_fails = reset_fails + 1;
        end

    // final step hands over to the done pulse
    a_last_done: assert property (@(posedge clk) disable iff (!reset)
        step && last_step |=> done)
        else begin
            $error("no done pulse after the final step");
            step_fails = step_fails + 1;
        end

endmodule

`default_nettype wire

// ==== verilog/restoring_divider.sv ====
// restoring divider top level: controller and datapath instances
`timescale 1ns/1ps
`default_nettype none

module restoring_divider
    import div_data_pkg::*;
#(
    parameter int data_width = div_default_width
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic [data_width-1:0] dividend,
    input  logic [data_width-1:0] divisor,
    output logic                  busy,
    output logic                  done,
    output logic [data_width-1:0] quotient,
    output logic [data_width-1:0] remainder
);

    // controller to datapath strobes
    logic load;
    logic step;
    // datapath back to controller
    logic last_step;

    // sequencer
    div_controller u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .last_step (last_step),
        .load      (load),
        .step      (step),
        .busy      (busy),
        .done      (done)
    );

    // shift, subtract, restore
    div_datapath #(
        .data_width (data_width)
    ) u_dp (
        .clk       (clk),
        .reset     (reset),
        .load      (load),
        .step      (step),
        .dividend  (dividend),
        .divisor   (divisor),
        .last_step (last_step),
        .quotient  (quotient),
        .remainder (remainder)
    );

endmodule

`default_nettype wire

// ==== verilog/div_controller.sv ====
// divider controller: idle/run/done sequencer with load and step strobes, busy and done
`timescale 1ns/1ps
`default_nettype none

module div_controller
    import div_ctrl_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic last_step,
    output logic load,
    output logic step,
    output logic busy,
    output logic done
);

    div_state_t state;
    div_state_t state_next;

    // state register
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= state_idle;
        end else begin
            state <= state_next;
        end
    end

    // next state
    // start counts only in idle, anything else ignores it
    always_comb begin
        state_next = state;
        case (state)
            state_idle: begin
                if (start) begin
                    state_next = state_run;
                end
            end
            state_run: begin
                // leave after the final step edge
                if (last_step) begin
                    state_next = state_done;
                end
            end
            state_done: begin
                // one cycle of done, then back to waiting
                state_next = state_idle;
            end
            default: begin
                state_next = state_idle;
            end
        endcase
    end

    // load strobe
    // combinational from start so the accepting edge captures operands
    assign load = (state == state_idle) && start;

    // one datapath step per run cycle
    assign step = (state == state_run);

    // busy covers run and the done cycle
    assign busy = (state != state_idle);

    // result pulse
    assign done = (state == state_done);

endmodule

`default_nettype wire

// ==== verilog/div_datapath.sv ====
// restoring divider datapath: operand and result registers, step counter, restore mux
`timescale 1ns/1ps
`default_nettype none

module div_datapath
    import div_data_pkg::*;
#(
    parameter int data_width = div_default_width
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load,
    input  logic                  step,
    input  logic [data_width-1:0] dividend,
    input  logic [data_width-1:0] divisor,
    output logic                  last_step,
    output logic [data_width-1:0] quotient,
    output logic [data_width-1:0] remainder
);

    // step counter width, derived from the operand width
    localparam int cnt_width = div_count_width(data_width);

    // index of the final step
    localparam logic [cnt_width-1:0] last_count = cnt_width'(data_width - 1);

    // width sanity, the shift needs at least two bits
    if (data_width < 2) begin : g_width_check
        $error("div_datapath needs data_width of 2 or more");
    end

    // partial remainder, one extra bit for the sign of the trial
    logic [data_width:0]     rem_q;
    // dividend shift register, its msb feeds the remainder each step
    logic [data_width-1:0]   dvd_q;
    // divisor, held for the whole division
    logic [data_width-1:0]   dsr_q;
    // quotient bits shift in from the right
    logic [data_width-1:0]   quo_q;
    logic [cnt_width-1:0]    count_q;

    // combinational step values
    logic [2*data_width:0]   shifted;
    logic [data_width:0]     shifted_rem;
    logic [data_width-1:0]   shifted_dvd;
    logic [data_width:0]     diff;
    logic [data_width:0]     rem_next;
    logic                    quo_bit;

    // shift remainder and dividend left together as one word
    always_comb begin
        shifted     = {rem_q, dvd_q} << 1;
        shifted_rem = shifted[2*data_width:data_width];
        shifted_dvd = shifted[data_width-1:0];
    end

    // trial subtraction
    // sign bit set means the divisor did not fit
    always_comb begin
        diff     = shifted_rem - {1'b0, dsr_q};
        quo_bit  = ~diff[data_width];
        // restore mux
        rem_next = diff[data_width] ? shifted_rem : diff;
    end

    // partial remainder
    // cleared at reset so the outputs read zero before any start
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rem_q <= '0;
        end else if (load) begin
            rem_q <= '0;
        end else if (step) begin
            rem_q <= rem_next;
        end
    end

    // quotient, one new bit per step
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            quo_q <= '0;
        end else if (load) begin
            quo_q <= '0;
        end else if (step) begin
            quo_q <= {quo_q[data_width-2:0], quo_bit};
        end
    end

    // operand registers, loaded at start
    always_ff @(posedge clk) begin
        if (load) begin
            dvd_q <= dividend;
            dsr_q <= divisor;
        end else if (step) begin
            // divisor just holds
            dvd_q <= shifted_dvd;
        end
    end

    // step counter
    // counts completed steps, cleared on every accepted start
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            count_q <= '0;
        end else if (load) begin
            count_q <= '0;
        end else if (step) begin
            count_q <= count_q + 1'b1;
        end
    end

    // final step flag, only while stepping
    assign last_step = step && (count_q == last_count);

    // results
    // top remainder bit is always clear once a step finishes
    assign quotient  = quo_q;
    assign remainder = rem_q[data_width-1:0];

endmodule

`default_nettype wire

// ==== verilog/div_ctrl_pkg.sv ====
// divider controller state encoding
`default_nettype none

package div_ctrl_pkg;

    // sequencer states, two bits
    // idle waits for start, run steps the datapath,
    // done is the one-cycle result pulse
    typedef enum logic [1:0] {
        state_idle = 2'b00,
        state_run  = 2'b01,
        state_done = 2'b10
    } div_state_t;

endpackage

`default_nettype wire

// ==== verilog/div_data_pkg.sv ====
// divider operand sizing: default operand width and step counter width helper
`default_nettype none

package div_data_pkg;

    // operand width used by the top level and the testbench
    localparam int div_default_width = 16;

    // bits needed to count steps 0 .. width-1
    // never below one bit, so width 2 still gets a counter
    function automatic int div_count_width(input int width);
        int bits;
        bits = $clog2(width);
        if (bits < 1) begin
            bits = 1;
        end
        return bits;
    endfunction

endpackage

`default_nettype wire
